// ==== project.f ====
+incdir+verilog
verilog/cpu_pkg.sv
verilog/control.sv
verilog/operand_fetch.sv
verilog/execute.sv
verilog/fetch.sv
verilog/single_cycle.sv
test/tb_single_cycle.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the single-cycle CPU testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -f project.f --top-module tb_single_cycle \
	-Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vtb_single_cycle" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
	exit 1
fi
exit 0

// ==== test/tb_single_cycle.sv ====
`timescale 1ns/1ns
`include "cpu_defines.svh"

module tb_single_cycle;

	localparam int NUM_INSTR = 2000;
	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 5;
	localparam int WATCHDOG_NS = (NUM_INSTR + RESET_CYCLES + 50) * CLK_PERIOD;

	logic clk;
	logic reset;
	logic [31:0] instr;
	logic [31:0] pc;
	logic commit_rf_enable;
	logic [4:0] commit_rf_addr;
	logic [31:0] commit_rf_data;
	logic commit_dm_enable;
	logic [`DM_ADDR_BITS-1:0] commit_dm_addr;
	logic [31:0] commit_dm_data;

	logic [31:0] program_mem [0:255];
	logic [31:0] model_regs [0:31];
	logic [31:0] model_dm [0:`DM_DEPTH-1];
	bit model_dm_known [0:`DM_DEPTH-1];
	logic [31:0] model_pc;
	int errors;
	int checks;

	single_cycle dut0 (.clk, .reset, .instr, .pc, .commit_rf_enable, .commit_rf_addr,
		.commit_rf_data, .commit_dm_enable, .commit_dm_addr, .commit_dm_data);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		assert (actual === expected)
		else begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s expected 0x%08x actual 0x%08x",
				$time, name, expected, actual);
		end
	endtask

	function automatic logic [31:0] random_instr();
		int kind;
		int offset;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [5:0] op;
		logic [31:0] word;
		kind = int'($urandom % 16);
		rs = 5'($urandom % 8);	// Small register set, values get reused
		rt = 5'($urandom % 8);
		rd = 5'($urandom % 8);
		case (kind)
			0, 1, 2: word = {`OP_RTYPE, rs, rt, rd, 5'd0, `FUNCT_ADDU};
			3, 4: word = {`OP_RTYPE, rs, rt, rd, 5'd0, `FUNCT_SUBU};
			5, 6: word = {`OP_ORI, rs, rt, 16'($urandom)};
			7: word = {`OP_LUI, rs, rt, 16'($urandom)};	// rs is don't-care
			8, 9: word = {`OP_LW, 5'd0, rt, 16'(($urandom % 64) * 4)};
			10, 11: word = {`OP_SW, 5'd0, rt, 16'(($urandom % 64) * 4)};
			12, 13: begin
				offset = int'($urandom % 17) - 8;
				if (offset == -1)
					offset = 1;	// No branch to itself
				// Only forward branches are forced taken, keeps loops rare
				if (offset < 0 && rs == rt)
					rt = rs + 5'd1;
				else if (offset >= 0 && ($urandom % 2) == 0)
					rt = rs;
				word = {`OP_BEQ, rs, rt, 16'(offset)};
			end
			15: begin
				op = 6'($urandom);
				while (op == `OP_LUI || op == `OP_ORI || op == `OP_LW || op == `OP_SW ||
						op == `OP_BEQ)
					op = 6'($urandom);
				word = {op, 26'($urandom)};
				if (op == `OP_RTYPE && (word[5:0] == `FUNCT_ADDU || word[5:0] == `FUNCT_SUBU))
					word[5:0] = 6'h3f;
			end
			default: word = 32'd0;	// nop
		endcase
		return word;
	endfunction

	// One instruction: drive it, compare commits with the model, then retire it
	task automatic run_instruction();
		logic [31:0] w;
		logic [4:0] rt;
		logic [4:0] dest;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] addr;
		logic [31:0] result;
		logic [31:0] next_pc;
		logic [`DM_ADDR_BITS-1:0] word;
		logic writes;
		logic stores;
		logic known;
		logic rf_en;
		check_value("pc", pc, model_pc);
		w = program_mem[pc[9:2]];
		instr = w;
		@(negedge clk);
		rt = w[`F_RT];
		a = model_regs[w[`F_RS]];
		b = model_regs[rt];
		simm = {{16{w[15]}}, w[`F_IMM]};
		addr = a + simm;
		word = addr[`DM_ADDR_BITS+1:2];
		next_pc = model_pc + 32'd4;
		dest = rt;
		result = 32'd0;
		writes = 1'b0;
		stores = 1'b0;
		known = 1'b1;
		case (w[`F_OP])
			`OP_RTYPE: begin
				dest = w[`F_RD];
				writes = (w[`F_FUNCT] == `FUNCT_ADDU) || (w[`F_FUNCT] == `FUNCT_SUBU);
				result = (w[`F_FUNCT] == `FUNCT_ADDU) ? a + b : a - b;
			end
			`OP_ORI: begin
				writes = 1'b1;
				result = a | {16'd0, w[`F_IMM]};
			end
			`OP_LUI: begin
				writes = 1'b1;
				result = {w[`F_IMM], 16'd0};
			end
			`OP_LW: begin
				writes = 1'b1;
				result = model_dm[word];
				known = model_dm_known[word];
			end
			`OP_SW: stores = 1'b1;
			`OP_BEQ: if (a == b) next_pc = next_pc + {simm[29:0], 2'b00};
			default: ;
		endcase
		rf_en = writes && (dest != 5'd0);
		check_value("commit_rf_enable", 32'(commit_rf_enable), 32'(rf_en));
		check_value("commit_dm_enable", 32'(commit_dm_enable), 32'(stores));
		if (rf_en) begin
			check_value("commit_rf_addr", 32'(commit_rf_addr), 32'(dest));
			if (known)
				check_value("commit_rf_data", commit_rf_data, result);
			else
				result = commit_rf_data;	// Unwritten memory word, register takes the read
			model_regs[dest] = result;
		end
		if (stores) begin
			check_value("commit_dm_addr", 32'(commit_dm_addr), 32'(word));
			check_value("commit_dm_data", commit_dm_data, b);
			model_dm[word] = b;
			model_dm_known[word] = 1'b1;
		end
		model_pc = next_pc;
	endtask

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instr = 32'd0;
		errors = 0;
		checks = 0;
		void'($urandom(87));
		for (int i = 0; i < 32; i++)
			model_regs[i] = 32'd0;
		for (int i = 0; i < `DM_DEPTH; i++)
			model_dm_known[i] = 1'b0;
		model_pc = `RESET_PC;
		program_mem[0] = {`OP_RTYPE, 5'd2, 5'd3, 5'd1, 5'd0, `FUNCT_ADDU};	// Shows cleared regs
		for (int i = 1; i < 256; i++)
			program_mem[i] = random_instr();
		repeat (RESET_CYCLES - 1) @(posedge clk);
		@(negedge clk);
		check_value("commit_rf_enable", 32'(commit_rf_enable), 32'd0);
		check_value("commit_dm_enable", 32'(commit_dm_enable), 32'd0);
		@(posedge clk);
		#2;
		reset = 1'b0;
		for (int n = 0; n < NUM_INSTR; n++) begin
			run_instruction();
			@(posedge clk);
			#2;
		end
		check_value("pc", pc, model_pc);	// Next PC of the last instruction
		finish_run();
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		errors++;
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		finish_run();
	end

endmodule

// ==== verilog/single_cycle.sv ====
`timescale 1ns/1ns
`include "cpu_defines.svh"

module single_cycle (
	input logic clk,
	input logic reset,
	input logic [31:0] instr,
	output logic [31:0] pc,
	output logic commit_rf_enable,
	output logic [4:0] commit_rf_addr,
	output logic [31:0] commit_rf_data,
	output logic commit_dm_enable,
	output logic [`DM_ADDR_BITS-1:0] commit_dm_addr,
	output logic [31:0] commit_dm_data
);
	import cpu_pkg::*;

	logic rf_write_enable;
	logic rf_dest_rd;
	logic alu_src_imm;
	logic alu_a_zero;
	logic mem_to_reg;
	logic dm_write_enable;
	alu_op_t alu_op;
	ext_mode_t ext_mode;
	npc_mode_t npc_mode;
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic [31:0] imm_ext;
	logic branch_taken;

	control control0 (.instr, .rf_write_enable, .rf_dest_rd, .alu_src_imm, .alu_a_zero,
		.mem_to_reg, .dm_write_enable, .alu_op, .ext_mode, .npc_mode);

	// Commit ports are the write-back and store wires themselves
	operand_fetch operand_fetch0 (.clk, .reset, .instr, .ext_mode,
		.wb_enable(commit_rf_enable), .wb_addr(commit_rf_addr), .wb_data(commit_rf_data),
		.rs_data, .rt_data, .imm_ext);

	execute execute0 (.clk, .reset, .instr, .rs_data, .rt_data, .imm_ext, .rf_write_enable,
		.rf_dest_rd, .alu_src_imm, .alu_a_zero, .mem_to_reg, .dm_write_enable, .alu_op,
		.npc_mode, .wb_enable(commit_rf_enable), .wb_addr(commit_rf_addr),
		.wb_data(commit_rf_data), .dm_write(commit_dm_enable), .dm_addr(commit_dm_addr),
		.dm_data(commit_dm_data), .branch_taken);

	fetch fetch0 (.clk, .reset, .branch_taken, .imm_ext, .pc);

endmodule

// ==== verilog/fetch.sv ====
`timescale 1ns/1ns
`include "cpu_defines.svh"

module fetch (
	input logic clk,
	input logic reset,
	input logic branch_taken,
	input logic [31:0] imm_ext,
	output logic [31:0] pc
);
	import cpu_pkg::*;

	logic [31:0] pc_plus4;
	logic [31:0] pc_next;

	assign pc_plus4 = pc + 32'd4;

	// Offset is in words
	assign pc_next = branch_taken ? pc_plus4 + {imm_ext[29:0], 2'b00} : pc_plus4;

	always_ff @(posedge clk) begin
		if (reset)
			pc <= `RESET_PC;
		else
			pc <= pc_next;
	end

	// Word-aligned through every branch
	assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
		else $error("fetch: pc 0x%08x not word aligned", pc);

endmodule

// ==== verilog/execute.sv ====
`timescale 1ns/1ns
`include "cpu_defines.svh"

module execute (
	input logic clk,
	input logic reset,
	input logic [31:0] instr,
	input logic [31:0] rs_data,
	input logic [31:0] rt_data,
	input logic [31:0] imm_ext,
	input logic rf_write_enable,
	input logic rf_dest_rd,
	input logic alu_src_imm,
	input logic alu_a_zero,
	input logic mem_to_reg,
	input logic dm_write_enable,
	input cpu_pkg::alu_op_t alu_op,
	input cpu_pkg::npc_mode_t npc_mode,
	output logic wb_enable,
	output logic [4:0] wb_addr,
	output logic [31:0] wb_data,
	output logic dm_write,
	output logic [`DM_ADDR_BITS-1:0] dm_addr,
	output logic [31:0] dm_data,
	output logic branch_taken
);
	import cpu_pkg::*;

	logic [31:0] alu_a;
	logic [31:0] alu_b;
	logic [31:0] alu_result;
	logic [31:0] dm_rdata;
	logic [31:0] dm [0:`DM_DEPTH-1];

	assign alu_a = alu_a_zero ? 32'd0 : rs_data;	// lui
	assign alu_b = alu_src_imm ? imm_ext : rt_data;

	always_comb begin
		case (alu_op)
			ALU_ADD: alu_result = alu_a + alu_b;
			ALU_SUB: alu_result = alu_a - alu_b;
			default: alu_result = alu_a | alu_b;
		endcase
	end

	// Word addressed data memory
	assign dm_addr = alu_result[`DM_ADDR_BITS+1:2];
	assign dm_data = rt_data;
	assign dm_write = dm_write_enable;
	assign dm_rdata = dm[dm_addr];

	always_ff @(posedge clk) begin
		if (dm_write && !reset)
			dm[dm_addr] <= dm_data;
	end

	// Write-back, nothing goes to register 0
	assign wb_addr = rf_dest_rd ? instr[`F_RD] : instr[`F_RT];
	assign wb_enable = rf_write_enable && (wb_addr != 5'd0);
	assign wb_data = mem_to_reg ? dm_rdata : alu_result;

	assign branch_taken = (npc_mode == NPC_BEQ) && (rs_data == rt_data);

endmodule

// ==== verilog/operand_fetch.sv ====
`timescale 1ns/1ns
`include "cpu_defines.svh"

module operand_fetch (
	input logic clk,
	input logic reset,
	input logic [31:0] instr,
	input cpu_pkg::ext_mode_t ext_mode,
	input logic wb_enable,
	input logic [4:0] wb_addr,
	input logic [31:0] wb_data,
	output logic [31:0] rs_data,
	output logic [31:0] rt_data,
	output logic [31:0] imm_ext
);
	import cpu_pkg::*;

	logic [31:0] regs [0:31];
	logic [15:0] imm;

	assign imm = instr[`F_IMM];

	// Register 0 is held at zero by the write filter in execute
	assign rs_data = regs[instr[`F_RS]];
	assign rt_data = regs[instr[`F_RT]];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'd0;
		end else if (wb_enable) begin
			regs[wb_addr] <= wb_data;
		end
	end

	always_comb begin
		case (ext_mode)
			EXT_SIGN: imm_ext = {{16{imm[15]}}, imm};
			EXT_UPPER: imm_ext = {imm, 16'd0};
			default: imm_ext = {16'd0, imm};	// Zero extension
		endcase
	end

	// Register 0 stays zero however write-back is addressed
	assert property (@(posedge clk) disable iff (reset) regs[0] == 32'd0)
		else $error("operand_fetch: register 0 written");

endmodule

// ==== verilog/control.sv ====
`timescale 1ns/1ns
`include "cpu_defines.svh"

module control (
	input logic [31:0] instr,
	output logic rf_write_enable,
	output logic rf_dest_rd,
	output logic alu_src_imm,
	output logic alu_a_zero,
	output logic mem_to_reg,
	output logic dm_write_enable,
	output cpu_pkg::alu_op_t alu_op,
	output cpu_pkg::ext_mode_t ext_mode,
	output cpu_pkg::npc_mode_t npc_mode
);
	import cpu_pkg::*;

	instr_kind_t kind;

	// Opcode and funct to kind
	always_comb begin
		kind = KIND_NOP;
		case (instr[`F_OP])
			`OP_RTYPE: begin
				if (instr[`F_FUNCT] == `FUNCT_ADDU)
					kind = KIND_ADDU;
				else if (instr[`F_FUNCT] == `FUNCT_SUBU)
					kind = KIND_SUBU;
			end
			`OP_LUI: kind = KIND_LUI;
			`OP_ORI: kind = KIND_ORI;
			`OP_LW: kind = KIND_LW;
			`OP_SW: kind = KIND_SW;
			`OP_BEQ: kind = KIND_BEQ;
			default: kind = KIND_NOP;
		endcase
	end

	always_comb begin
		rf_write_enable = 1'b0;
		rf_dest_rd = 1'b0;	// rt unless R-type
		alu_src_imm = 1'b0;
		alu_a_zero = 1'b0;
		mem_to_reg = 1'b0;
		dm_write_enable = 1'b0;
		alu_op = ALU_OR;
		ext_mode = EXT_ZERO;
		npc_mode = NPC_SEQ;
		case (kind)
			KIND_ADDU, KIND_SUBU: begin
				rf_write_enable = 1'b1;
				rf_dest_rd = 1'b1;
				alu_op = (kind == KIND_ADDU) ? ALU_ADD : ALU_SUB;
			end
			KIND_ORI: begin
				rf_write_enable = 1'b1;
				alu_src_imm = 1'b1;
			end
			KIND_LUI: begin
				rf_write_enable = 1'b1;
				alu_src_imm = 1'b1;
				alu_a_zero = 1'b1;	// rs field is don't-care
				ext_mode = EXT_UPPER;
			end
			KIND_LW, KIND_SW: begin
				rf_write_enable = (kind == KIND_LW);
				dm_write_enable = (kind == KIND_SW);
				mem_to_reg = (kind == KIND_LW);
				alu_src_imm = 1'b1;
				alu_op = ALU_ADD;
				ext_mode = EXT_SIGN;
			end
			KIND_BEQ: begin
				npc_mode = NPC_BEQ;
				ext_mode = EXT_SIGN;	// Branch offset
			end
			default: ;
		endcase
	end

	// A store never writes the register file
	always_comb
		assert (!(dm_write_enable && rf_write_enable))
			else $error("control: store and register write together");

endmodule

// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

	// Decoded instruction, unknown encodings fold into nop
	typedef enum logic [3:0] {
		KIND_ADDU,
		KIND_SUBU,
		KIND_LUI,
		KIND_ORI,
		KIND_LW,
		KIND_SW,
		KIND_BEQ,
		KIND_NOP
	} instr_kind_t;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_OR
	} alu_op_t;

	// Immediate extension
	typedef enum logic [1:0] {
		EXT_ZERO,
		EXT_SIGN,
		EXT_UPPER	// imm in bits 31:16
	} ext_mode_t;

	typedef enum logic {
		NPC_SEQ,
		NPC_BEQ
	} npc_mode_t;

endpackage

// ==== verilog/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Opcodes
`define OP_RTYPE 6'h00
`define OP_LUI 6'h0f
`define OP_ORI 6'h0d
`define OP_LW 6'h23
`define OP_SW 6'h2b
`define OP_BEQ 6'h04

`define FUNCT_ADDU 6'h21	// R-type funct
`define FUNCT_SUBU 6'h23

// Instruction field positions
`define F_OP 31:26
`define F_RS 25:21
`define F_RT 20:16
`define F_RD 15:11
`define F_FUNCT 5:0
`define F_IMM 15:0

`define DM_ADDR_BITS 6	// 64 words
`define DM_DEPTH (1 << `DM_ADDR_BITS)
`define RESET_PC 32'h0000_0000

`endif
